// ==== verilog.f ====
logic/player_pkg.sv
logic/command_decoder.sv
logic/sample_rate_control.sv
logic/flash_fetch.sv
logic/sample_unpacker.sv
logic/ipod_player_top.sv
test/flash_model.sv
test/tb_ipod_player.sv

// ==== Bender.yml ====
package:
  name: ipod_player

sources:
  - logic/player_pkg.sv
  - logic/command_decoder.sv
  - logic/sample_rate_control.sv
  - logic/flash_fetch.sv
  - logic/sample_unpacker.sv
  - logic/ipod_player_top.sv
  - target: test
    files:
      - test/flash_model.sv
      - test/tb_ipod_player.sv

// ==== test/tb_ipod_player.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ipod_player;

  import player_pkg::*;

  logic                CLK_50M = 1'b0;
  logic                reset;
  logic [ASCII_W-1:0]  key_ascii;
  logic                key_ready;
  logic                speed_up;
  logic                speed_down;
  logic                speed_reset;
  logic                mem_waitrequest;
  logic [WORD_W-1:0]   mem_readdata;
  logic                mem_readdatavalid;
  logic                mem_read;
  logic [ADDR_W-1:0]   mem_address;
  logic [SAMPLE_W-1:0] sample;
  logic                sample_valid;
  logic [DIV_W-1:0]    rate_div;

  // Reference model of the player
  logic                exp_playing;
  logic                exp_reverse;
  logic [ADDR_W-1:0]   cur_addr;
  logic [ADDR_W-1:0]   next_addr;
  logic                cur_half;
  logic [DIV_W-1:0]    exp_rate;
  logic [DIV_W-1:0]    gap_cnt;
  logic                gap_armed;
  logic [SAMPLE_W-1:0] exp_sample;

  int error_count = 0;
  int test_count = 0;
  int fail_count = 0;
  int test_start_errors = 0;

  always #10 CLK_50M = ~CLK_50M;

  ipod_player_top ipod_player_top_inst (
    .CLK_50M           (CLK_50M),
    .reset             (reset),
    .key_ascii         (key_ascii),
    .key_ready         (key_ready),
    .speed_up          (speed_up),
    .speed_down        (speed_down),
    .speed_reset       (speed_reset),
    .mem_waitrequest   (mem_waitrequest),
    .mem_readdata      (mem_readdata),
    .mem_readdatavalid (mem_readdatavalid),
    .mem_read          (mem_read),
    .mem_address       (mem_address),
    .sample            (sample),
    .sample_valid      (sample_valid),
    .rate_div          (rate_div)
  );

  flash_model flash_model_inst (
    .CLK_50M           (CLK_50M),
    .reset             (reset),
    .mem_read          (mem_read),
    .mem_address       (mem_address),
    .mem_waitrequest   (mem_waitrequest),
    .mem_readdata      (mem_readdata),
    .mem_readdatavalid (mem_readdatavalid)
  );

  function automatic logic [ADDR_W-1:0] adjacent_word(input logic [ADDR_W-1:0] addr,
                                                      input logic              rev);
    if (rev)
      return (addr == '0) ? LAST_WORD_ADDR : addr - 1'b1;
    return (addr == LAST_WORD_ADDR) ? '0 : addr + 1'b1;
  endfunction

  // Flash data holds the address byte in bits 15:8, its inverse in bits 31:24
  assign exp_sample = (cur_half ^ exp_reverse) ? ~cur_addr[7:0] : cur_addr[7:0];

  // ======================================================================
  // Reference model
  // ======================================================================
  always @(posedge CLK_50M)
  begin
    if (reset)
    begin
      exp_playing <= 1'b0;
      exp_reverse <= 1'b0;
      cur_addr    <= '0;
      next_addr   <= ADDR_W'(1);
      cur_half    <= 1'b0;
      exp_rate    <= DEFAULT_RATE_DIV;
      gap_cnt     <= '0;
      gap_armed   <= 1'b0;
    end
    else
    begin
      gap_cnt <= gap_cnt + 1'b1;
      if (sample_valid)
      begin
        gap_cnt   <= DIV_W'(1);
        gap_armed <= 1'b1;
        cur_half  <= ~cur_half;
        if (cur_half)
        begin
          // Following address is fixed when the next word is fetched
          cur_addr  <= next_addr;
          next_addr <= adjacent_word(next_addr, exp_reverse);
        end
      end
      if (key_ready)
      begin
        gap_armed <= 1'b0;
        case (key_ascii)
          "E", "e": exp_playing <= 1'b1;
          "D", "d": exp_playing <= 1'b0;
          "F", "f": exp_reverse <= 1'b0;
          "B", "b": exp_reverse <= 1'b1;
          "R", "r": next_addr <= exp_reverse ? LAST_WORD_ADDR : '0;
          default:  ;
        endcase
      end
      if (speed_up || speed_down || speed_reset)
      begin
        gap_armed <= 1'b0;
        if (speed_reset)
          exp_rate <= DEFAULT_RATE_DIV;
        else if (speed_up)
          exp_rate <= (exp_rate - RATE_STEP < RATE_DIV_MIN) ?
                      RATE_DIV_MIN : exp_rate - RATE_STEP;
        else
          exp_rate <= (exp_rate + RATE_STEP > RATE_DIV_MAX) ?
                      RATE_DIV_MAX : exp_rate + RATE_STEP;
      end
    end
  end

  // ======================================================================
  // Checks
  // ======================================================================
  sample_value_check: assert property (
    @(posedge CLK_50M) disable iff (reset) sample_valid |-> (sample == exp_sample)
  ) else
  begin
    $display("CHECK FAILED sample: got 0x%h, expected 0x%h (word 0x%h)",
             $sampled(sample), $sampled(exp_sample), $sampled(cur_addr));
    error_count++;
  end

  // At the first half of a word its own read is the last one issued
  fetch_address_check: assert property (
    @(posedge CLK_50M) disable iff (reset)
      (sample_valid && !cur_half) |-> (mem_address == cur_addr)
  ) else
  begin
    $display("CHECK FAILED mem_address: got 0x%h, expected 0x%h",
             $sampled(mem_address), $sampled(cur_addr));
    error_count++;
  end

  fetch_done_check: assert property (
    @(posedge CLK_50M) disable iff (reset)
      (sample_valid && !cur_half) |-> !mem_read
  ) else
  begin
    $display("CHECK FAILED mem_read: got 0x%h, expected 0x0", $sampled(mem_read));
    error_count++;
  end

  sample_spacing_check: assert property (
    @(posedge CLK_50M) disable iff (reset)
      (sample_valid && gap_armed) |-> (gap_cnt == exp_rate)
  ) else
  begin
    $display("CHECK FAILED sample_valid spacing: got 0x%h, expected 0x%h",
             $sampled(gap_cnt), $sampled(exp_rate));
    error_count++;
  end

  rate_div_check: assert property (
    @(posedge CLK_50M) disable iff (reset) rate_div == exp_rate
  ) else
  begin
    $display("CHECK FAILED rate_div: got 0x%h, expected 0x%h",
             $sampled(rate_div), $sampled(exp_rate));
    error_count++;
  end

  paused_quiet_check: assert property (
    @(posedge CLK_50M) disable iff (reset) !exp_playing |-> !sample_valid
  ) else
  begin
    $display("Error: sample_valid pulsed while playback was paused");
    error_count++;
  end

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge CLK_50M);
  endtask

  task automatic press_key(input logic [ASCII_W-1:0] code);
    @(negedge CLK_50M);
    key_ascii = code;
    key_ready = 1'b1;
    @(negedge CLK_50M);
    key_ready = 1'b0;
    idle_cycles(2);
  endtask

  task automatic pulse_speed(input logic up, input logic down, input logic restore);
    @(negedge CLK_50M);
    speed_up    = up;
    speed_down  = down;
    speed_reset = restore;
    @(negedge CLK_50M);
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
  endtask

  task automatic wait_samples(input int count);
    int seen;
    int cycles;
    int limit;
    seen   = 0;
    cycles = 0;
    limit  = (count + 1) * (int'(exp_rate) + 64);
    while (seen < count && cycles < limit)
    begin
      @(negedge CLK_50M);
      cycles++;
      if (sample_valid)
        seen++;
    end
    if (seen < count)
    begin
      $display("Timeout: only %0d of %0d sample pulses arrived", seen, count);
      error_count++;
    end
  endtask

  task automatic end_test(input string name);
    test_count++;
    if (error_count == test_start_errors)
      $display("Test %0d %s: ok", test_count, name);
    else
    begin
      fail_count++;
      $display("Test %0d %s: %0d errors", test_count, name, error_count - test_start_errors);
    end
    test_start_errors = error_count;
  endtask

  // ======================================================================
  // Stimulus
  // ======================================================================
  initial
  begin
    reset       = 1'b1;
    key_ascii   = '0;
    key_ready   = 1'b0;
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
    repeat (8) @(posedge CLK_50M);
    @(negedge CLK_50M);
    reset = 1'b0;

    idle_cycles(3000);
    end_test("reset idle");

    press_key("E");
    wait_samples(8);
    end_test("forward play");

    // Keys go in well clear of the fetch that follows a word boundary
    idle_cycles(40);
    press_key("d");
    idle_cycles(3000);
    press_key("e");
    wait_samples(4);
    idle_cycles(40);
    press_key("d");
    press_key("B");
    press_key("R");
    press_key("E");
    wait_samples(6);
    end_test("pause and direction");

    idle_cycles(40);
    press_key("f");
    wait_samples(14);
    end_test("address wrap");

    idle_cycles(40);
    repeat (3) pulse_speed(1'b1, 1'b0, 1'b0);
    wait_samples(4);
    pulse_speed(1'b0, 1'b1, 1'b0);
    wait_samples(4);
    repeat (130) pulse_speed(1'b1, 1'b0, 1'b0);
    wait_samples(4);
    pulse_speed(1'b0, 1'b0, 1'b1);
    wait_samples(4);
    end_test("speed control");

    $display("Tests %0d, failed %0d, errors %0d", test_count, fail_count, error_count);
    if (error_count == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/flash_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module flash_model (
  input  logic                          CLK_50M,
  input  logic                          reset,
  input  logic                          mem_read,
  input  logic [player_pkg::ADDR_W-1:0] mem_address,
  output logic                          mem_waitrequest,
  output logic [player_pkg::WORD_W-1:0] mem_readdata,
  output logic                          mem_readdatavalid
);

  import player_pkg::*;

  integer            seed = 46;
  logic [1:0]        wait_left;
  int                latency_left;
  logic              busy;
  logic [ADDR_W-1:0] read_addr;

  function automatic int draw_below(input int bound);
    int r;
    r = $random(seed) & 32'h7fffffff;
    return r % bound;
  endfunction

  // Stall the read until the drawn wait count has run out
  assign mem_waitrequest = mem_read && (wait_left != 2'd0);

  always @(posedge CLK_50M)
  begin
    if (reset)
    begin
      wait_left         <= 2'(draw_below(4));
      latency_left      <= 0;
      busy              <= 1'b0;
      read_addr         <= '0;
      mem_readdata      <= '0;
      mem_readdatavalid <= 1'b0;
    end
    else
    begin
      mem_readdatavalid <= 1'b0;
      if (mem_read && wait_left != 2'd0)
        wait_left <= wait_left - 2'd1;
      else if (mem_read)
      begin
        // Accepted, draw this latency and the wait of the next read
        read_addr    <= mem_address;
        busy         <= 1'b1;
        latency_left <= 1 + draw_below(5);
        wait_left    <= 2'(draw_below(4));
      end
      if (busy)
      begin
        if (latency_left <= 1)
        begin
          busy              <= 1'b0;
          mem_readdatavalid <= 1'b1;
          // Low byte of each half stays zero
          mem_readdata      <= {~read_addr[7:0], 8'h00, read_addr[7:0], 8'h00};
        end
        else
          latency_left <= latency_left - 1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/ipod_player_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ipod_player_top (
  input  logic                           CLK_50M,
  input  logic                           reset,
  input  logic [player_pkg::ASCII_W-1:0]  key_ascii,
  input  logic                           key_ready,
  input  logic                           speed_up,
  input  logic                           speed_down,
  input  logic                           speed_reset,
  input  logic                           mem_waitrequest,
  input  logic [player_pkg::WORD_W-1:0]   mem_readdata,
  input  logic                           mem_readdatavalid,
  output logic                           mem_read,
  output logic [player_pkg::ADDR_W-1:0]   mem_address,
  output logic [player_pkg::SAMPLE_W-1:0] sample,
  output logic                           sample_valid,
  output logic [player_pkg::DIV_W-1:0]    rate_div
);

  import player_pkg::*;

  logic              playing;
  logic              reverse;
  logic              restart;
  logic              sample_strobe;
  logic              word_req;
  logic [WORD_W-1:0] word_data;
  logic              word_valid;

  // ======================================================================
  // Decode
  // ======================================================================
  command_decoder command_decoder_inst (
    .CLK_50M   (CLK_50M),
    .reset     (reset),
    .key_ascii (key_ascii),
    .key_ready (key_ready),
    .playing   (playing),
    .reverse   (reverse),
    .restart   (restart)
  );

  // ======================================================================
  // Execute
  // ======================================================================
  sample_rate_control sample_rate_control_inst (
    .CLK_50M       (CLK_50M),
    .reset         (reset),
    .playing       (playing),
    .speed_up      (speed_up),
    .speed_down    (speed_down),
    .speed_reset   (speed_reset),
    .rate_div      (rate_div),
    .sample_strobe (sample_strobe)
  );

  flash_fetch flash_fetch_inst (
    .CLK_50M           (CLK_50M),
    .reset             (reset),
    .reverse           (reverse),
    .restart           (restart),
    .word_req          (word_req),
    .mem_waitrequest   (mem_waitrequest),
    .mem_readdata      (mem_readdata),
    .mem_readdatavalid (mem_readdatavalid),
    .mem_read          (mem_read),
    .mem_address       (mem_address),
    .word_data         (word_data),
    .word_valid        (word_valid)
  );

  // ======================================================================
  // Result
  // ======================================================================
  sample_unpacker sample_unpacker_inst (
    .CLK_50M       (CLK_50M),
    .reset         (reset),
    .reverse       (reverse),
    .sample_strobe (sample_strobe),
    .word_data     (word_data),
    .word_valid    (word_valid),
    .word_req      (word_req),
    .sample        (sample),
    .sample_valid  (sample_valid)
  );

endmodule

`default_nettype wire

// ==== logic/sample_unpacker.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_unpacker (
  input  logic                           CLK_50M,
  input  logic                           reset,
  input  logic                           reverse,
  input  logic                           sample_strobe,
  input  logic [player_pkg::WORD_W-1:0]   word_data,
  input  logic                           word_valid,
  output logic                           word_req,
  output logic [player_pkg::SAMPLE_W-1:0] sample,
  output logic                           sample_valid
);

  import player_pkg::*;

  logic [WORD_W-1:0]   word_held;
  logic                have_word;
  logic                req_pending;
  logic                second_half;
  logic [SAMPLE_W-1:0] next_sample;

  // Upper byte of each 16-bit half, order set by direction
  always_comb
  begin
    if (second_half ^ reverse)
      next_sample = word_held[31:24];
    else
      next_sample = word_held[15:8];
  end

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      have_word    <= 1'b0;
      req_pending  <= 1'b0;
      second_half  <= 1'b0;
      word_req     <= 1'b0;
      sample_valid <= 1'b0;
    end
    else
    begin
      word_req     <= 1'b0;
      sample_valid <= 1'b0;
      if (word_valid)
      begin
        have_word   <= 1'b1;
        req_pending <= 1'b0;
        second_half <= 1'b0;
      end
      else if (sample_strobe && have_word)
      begin
        sample_valid <= 1'b1;
        second_half  <= ~second_half;
        if (second_half)
        begin
          // Word used up, ask for the next one
          have_word   <= 1'b0;
          word_req    <= 1'b1;
          req_pending <= 1'b1;
        end
      end
      // First request after reset
      if (!have_word && !req_pending && !word_req)
      begin
        word_req    <= 1'b1;
        req_pending <= 1'b1;
      end
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (word_valid)
      word_held <= word_data;
    if (!word_valid && sample_strobe && have_word)
      sample <= next_sample;
  end

endmodule

`default_nettype wire

// ==== logic/flash_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module flash_fetch (
  input  logic                         CLK_50M,
  input  logic                         reset,
  input  logic                         reverse,
  input  logic                         restart,
  input  logic                         word_req,
  input  logic                         mem_waitrequest,
  input  logic [player_pkg::WORD_W-1:0] mem_readdata,
  input  logic                         mem_readdatavalid,
  output logic                         mem_read,
  output logic [player_pkg::ADDR_W-1:0] mem_address,
  output logic [player_pkg::WORD_W-1:0] word_data,
  output logic                         word_valid
);

  import player_pkg::*;

  fetch_state_e      state;
  logic [ADDR_W-1:0] next_addr;
  logic [ADDR_W-1:0] restart_addr;
  logic              restart_pending;

  // Neighbouring word in play direction, wrapping at both ends
  function automatic logic [ADDR_W-1:0] step_addr(input logic [ADDR_W-1:0] addr,
                                                  input logic              rev);
    if (rev)
      return (addr == '0) ? LAST_WORD_ADDR : addr - 1'b1;
    else
      return (addr == LAST_WORD_ADDR) ? '0 : addr + 1'b1;
  endfunction

  assign restart_addr = reverse ? LAST_WORD_ADDR : '0;

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      state           <= FETCH_IDLE;
      mem_read        <= 1'b0;
      mem_address     <= '0;
      next_addr       <= '0;
      restart_pending <= 1'b0;
      word_valid      <= 1'b0;
    end
    else
    begin
      word_valid <= 1'b0;
      case (state)
        FETCH_IDLE:
        begin
          if (restart)
            next_addr <= restart_addr;
          if (word_req)
          begin
            mem_read    <= 1'b1;
            mem_address <= restart ? restart_addr : next_addr;
            state       <= FETCH_REQUEST;
          end
        end
        FETCH_REQUEST:
        begin
          if (restart)
            restart_pending <= 1'b1;
          // Read accepted on this edge
          if (!mem_waitrequest)
          begin
            mem_read <= 1'b0;
            state    <= FETCH_WAIT_DATA;
          end
        end
        FETCH_WAIT_DATA:
        begin
          if (restart)
            restart_pending <= 1'b1;
          if (mem_readdatavalid)
          begin
            if (restart || restart_pending)
            begin
              // Drop the stale word and read again from the restart point
              restart_pending <= 1'b0;
              mem_read        <= 1'b1;
              mem_address     <= restart_addr;
              state           <= FETCH_REQUEST;
            end
            else
            begin
              word_valid <= 1'b1;
              next_addr  <= step_addr(mem_address, reverse);
              state      <= FETCH_IDLE;
            end
          end
        end
        default:
          state <= FETCH_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (state == FETCH_WAIT_DATA && mem_readdatavalid)
      word_data <= mem_readdata;
  end

  mem_address_stable: assert property (
    @(posedge CLK_50M) disable iff (reset)
      (mem_read && mem_waitrequest) |=> (mem_read && $stable(mem_address))
  );

  // Unpacker keeps at most one request outstanding
  word_req_when_idle: assert property (
    @(posedge CLK_50M) disable iff (reset) word_req |-> (state == FETCH_IDLE)
  );

endmodule

`default_nettype wire

// ==== logic/sample_rate_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_rate_control (
  input  logic                        CLK_50M,
  input  logic                        reset,
  input  logic                        playing,
  input  logic                        speed_up,
  input  logic                        speed_down,
  input  logic                        speed_reset,
  output logic [player_pkg::DIV_W-1:0] rate_div,
  output logic                        sample_strobe
);

  import player_pkg::*;

  logic [DIV_W-1:0] rate_cnt;

  // ======================================================================
  // Sample period register
  // ======================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      rate_div <= DEFAULT_RATE_DIV;
    end
    else if (speed_reset)
    begin
      rate_div <= DEFAULT_RATE_DIV;
    end
    else if (speed_up)
    begin
      // Shorter period means faster play
      if (rate_div < RATE_DIV_MIN + RATE_STEP)
        rate_div <= RATE_DIV_MIN;
      else
        rate_div <= rate_div - RATE_STEP;
    end
    else if (speed_down)
    begin
      if (rate_div > RATE_DIV_MAX - RATE_STEP)
        rate_div <= RATE_DIV_MAX;
      else
        rate_div <= rate_div + RATE_STEP;
    end
  end

  // ======================================================================
  // Strobe counter
  // ======================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (reset || !playing)
    begin
      rate_cnt      <= '0;
      sample_strobe <= 1'b0;
    end
    else if (rate_cnt >= rate_div - 1'b1)
    begin
      // Also catches a period shortened below the running count
      rate_cnt      <= '0;
      sample_strobe <= 1'b1;
    end
    else
    begin
      rate_cnt      <= rate_cnt + 1'b1;
      sample_strobe <= 1'b0;
    end
  end

  rate_div_in_range: assert property (
    @(posedge CLK_50M) disable iff (reset)
      (rate_div >= RATE_DIV_MIN) && (rate_div <= RATE_DIV_MAX)
  );

endmodule

`default_nettype wire

// ==== logic/command_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module command_decoder (
  input  logic                          CLK_50M,
  input  logic                          reset,
  input  logic [player_pkg::ASCII_W-1:0] key_ascii,
  input  logic                          key_ready,
  output logic                          playing,
  output logic                          reverse,
  output logic                          restart
);

  import player_pkg::*;

  logic [ASCII_W-1:0] key_upper;
  player_cmd_e        key_cmd;

  // Fold lower case onto upper case
  assign key_upper = key_ascii & ~CASE_BIT;

  always_comb
  begin
    case (key_upper)
      KEY_UP_E: key_cmd = CMD_PLAY;
      KEY_UP_D: key_cmd = CMD_PAUSE;
      KEY_UP_F: key_cmd = CMD_FORWARD;
      KEY_UP_B: key_cmd = CMD_BACKWARD;
      KEY_UP_R: key_cmd = CMD_RESTART;
      default:  key_cmd = CMD_NONE;
    endcase
  end

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      playing <= 1'b0;
      reverse <= 1'b0;
      restart <= 1'b0;
    end
    else
    begin
      restart <= 1'b0;
      if (key_ready)
      begin
        case (key_cmd)
          CMD_PLAY:     playing <= 1'b1;
          CMD_PAUSE:    playing <= 1'b0;
          CMD_FORWARD:  reverse <= 1'b0;
          CMD_BACKWARD: reverse <= 1'b1;
          CMD_RESTART:  restart <= 1'b1;
          default:      ;
        endcase
      end
    end
  end

  // Fetch expects restart as a single-cycle event
  restart_single_pulse: assert property (
    @(posedge CLK_50M) disable iff (reset) restart |=> !restart
  );

endmodule

`default_nettype wire

// ==== logic/player_pkg.sv ====
`default_nettype none

package player_pkg;

  // ======================================================================
  // Widths and song address range
  // ======================================================================
  localparam int ADDR_W   = 23;
  localparam int WORD_W   = 32;
  localparam int SAMPLE_W = 8;
  localparam int ASCII_W  = 8;
  localparam int DIV_W    = 16;

  localparam logic [ADDR_W-1:0] LAST_WORD_ADDR = 23'h7FFFF;

  // ======================================================================
  // Sample period in CLK_50M cycles
  // ======================================================================
  // About 22 kHz at 50 MHz
  localparam logic [DIV_W-1:0] DEFAULT_RATE_DIV = 16'd2272;
  localparam logic [DIV_W-1:0] RATE_STEP        = 16'd16;
  localparam logic [DIV_W-1:0] RATE_DIV_MIN     = 16'd256;
  localparam logic [DIV_W-1:0] RATE_DIV_MAX     = 16'd8192;

  // Upper-case ASCII codes of the player keys
  localparam logic [ASCII_W-1:0] KEY_UP_E = 8'h45;
  localparam logic [ASCII_W-1:0] KEY_UP_D = 8'h44;
  localparam logic [ASCII_W-1:0] KEY_UP_F = 8'h46;
  localparam logic [ASCII_W-1:0] KEY_UP_B = 8'h42;
  localparam logic [ASCII_W-1:0] KEY_UP_R = 8'h52;

  // Set in lower-case letters only
  localparam logic [ASCII_W-1:0] CASE_BIT = 8'h20;

  typedef enum logic [2:0] {
    CMD_NONE,
    CMD_PLAY,
    CMD_PAUSE,
    CMD_FORWARD,
    CMD_BACKWARD,
    CMD_RESTART
  } player_cmd_e;

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_REQUEST,
    FETCH_WAIT_DATA
  } fetch_state_e;

endpackage

`default_nettype wire
